// ==== project.f ====
+incdir+include
hdl/axi2per_pkg.sv
hdl/axi2per_trans_if.sv
hdl/axi2per_chan_slice.sv
hdl/axi2per_req_channel.sv
hdl/axi2per_res_channel.sv
hdl/axi2per_bridge.sv
tb/tb_axi2per.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_axi2per
FILELIST = project.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb/tb_axi2per.sv ====
/*
 * Testbench for the AXI4 to peripheral bridge. Drives single-beat reads and
 * writes, models the peripheral as a word memory and checks every R and B
 * reply against a reference memory kept on the AXI side.
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi2per_consts.svh"

module tb_axi2per;

   localparam int CLK_HALF  = 4;
   localparam int RST_CYC   = 16;
   localparam int ARB_N     = 6;
   localparam int BE_N      = 4;
   localparam int BP_N      = 10;
   localparam int TOTAL_TXN = 2*ARB_N + 4 + 3*BE_N + 6 + 2*BP_N + 1;
   localparam int WDOG_CYC  = RST_CYC + 200*TOTAL_TXN;

   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      logic [`AXI_DATA_W-1:0] data;
      logic [1:0]             resp;
   } reply_t;

   typedef struct packed {
      logic [`AXI_ADDR_W-1:0]   addr;
      logic [`PER_DATA_W-1:0]   wdata;
      logic [`PER_DATA_W/8-1:0] be;
   } per_wr_t;

   logic clk_i, rst_n_i;
   logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, ar_valid_i, ar_ready_o;
   logic [`AXI_ADDR_W-1:0]   aw_addr_i, ar_addr_i, per_add_o;
   logic [7:0]               aw_len_i, ar_len_i, w_strb_i;
   logic [2:0]               aw_size_i, ar_size_i;
   logic [`AXI_ID_W-1:0]     aw_id_i, ar_id_i, r_id_o, b_id_o;
   logic [`AXI_DATA_W-1:0]   w_data_i, r_data_o;
   logic                     r_valid_o, r_ready_i, r_last_o, b_valid_o, b_ready_i;
   logic [1:0]               r_resp_o, b_resp_o;
   logic                     per_req_o, per_we_o, per_gnt_i, per_r_valid_i, per_r_opc_i;
   logic [`PER_DATA_W-1:0]   per_wdata_o, per_r_rdata_i;
   logic [`PER_DATA_W/8-1:0] per_be_o;
   logic                     busy_o;

   integer      seed = 32'hfc96_24ce;
   logic [31:0] exp_mem [bit [31:0]];
   logic [31:0] per_mem [bit [31:0]];
   reply_t      exp_r_q[$];
   reply_t      exp_b_q[$];
   per_wr_t     exp_wr_q[$];
   logic        grant_log[$];
   logic        log_grants;
   logic        bp_en;
   int          err_cnt = 0;
   int          check_cnt = 0;
   int          test_cnt = 0;
   int          test_fail_cnt = 0;
   int          test_err_base = 0;

   axi2per_bridge UUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   //**************************************************
   // Reference model
   //**************************************************
   function automatic bit [31:0] word_key(input logic [31:0] addr);
      return {2'b00, addr[31:2]};
   endfunction

   // Power-up content hashed from the word address
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      logic [31:0] w;
      w = {addr[31:2], 2'b00};
      return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]};
   endfunction

   function automatic logic err_region(input logic [31:0] addr);
      return addr[31:28] == 4'hf;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] nw,
                                               input logic [3:0]  be);
      logic [31:0] res;
      res = old;
      for (int i = 0; i < 4; i++) begin
         if (be[i]) res[i*8 +: 8] = nw[i*8 +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] ref_word(input logic [31:0] addr);
      return exp_mem.exists(word_key(addr)) ? exp_mem[word_key(addr)] : fill_word(addr);
   endfunction

   // Expected R or B reply of one access
   function automatic reply_t ref_reply(input logic we, input logic [31:0] addr,
                                        input logic [2:0] id);
      reply_t rep;
      rep.id   = id;
      rep.resp = err_region(addr) ? `RESP_SLVERR : `RESP_OKAY;
      if (we) rep.data = '0;
      else if (addr[2]) rep.data = {ref_word(addr), 32'h0};
      else rep.data = {32'h0, ref_word(addr)};
      return rep;
   endfunction

   //**************************************************
   // Checks and reporting
   //**************************************************
   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_cond(input logic ok, input string what);
      check_cnt++;
      assert (ok) else begin
         $display("Failure at %0t ns: %s", $time, what);
         err_cnt++;
      end
   endtask

   task automatic drain();
      while (exp_r_q.size() != 0 || exp_b_q.size() != 0) @(negedge clk_i);
      repeat (3) @(negedge clk_i);
   endtask

   task automatic finish_test(input string name);
      int errs;
      drain();
      check_cond(!busy_o && !per_req_o, "busy_o or per_req_o still high when idle");
      errs = err_cnt - test_err_base;
      test_cnt++;
      if (errs == 0) begin
         $display("test %s ok", name);
      end else begin
         test_fail_cnt++;
         $display("test %s failed with %0d errors", name, errs);
      end
      test_err_base = err_cnt;
   endtask

   //**************************************************
   // AXI master side
   //**************************************************
   task automatic send_ar(input logic [31:0] addr, input logic [2:0] id);
      @(negedge clk_i);
      ar_valid_i = 1'b1;
      ar_addr_i  = addr;
      ar_id_i    = id;
      while (!ar_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      ar_valid_i = 1'b0;
   endtask

   task automatic send_aw(input logic [31:0] addr, input logic [2:0] id);
      @(negedge clk_i);
      aw_valid_i = 1'b1;
      aw_addr_i  = addr;
      aw_id_i    = id;
      while (!aw_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      aw_valid_i = 1'b0;
   endtask

   task automatic send_w(input logic [63:0] data, input logic [7:0] strb);
      @(negedge clk_i);
      w_valid_i = 1'b1;
      w_data_i  = data;
      w_strb_i  = strb;
      while (!w_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      w_valid_i = 1'b0;
   endtask

   task automatic issue_read(input logic [31:0] addr, input logic [2:0] id);
      exp_r_q.push_back(ref_reply(1'b0, addr, id));
      send_ar(addr, id);
   endtask

   task automatic issue_write(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb, input logic [2:0] id);
      per_wr_t w;
      w.addr  = addr;
      w.wdata = addr[2] ? data[63:32] : data[31:0];
      w.be    = addr[2] ? strb[7:4] : strb[3:0];
      exp_wr_q.push_back(w);
      exp_b_q.push_back(ref_reply(1'b1, addr, id));
      if (!err_region(addr)) exp_mem[word_key(addr)] = merge_bytes(ref_word(addr), w.wdata, w.be);
      fork
         send_aw(addr, id);
         send_w(data, strb);
      join
   endtask

   // Response ready and reply comparison
   initial begin
      reply_t exp;
      r_ready_i = 1'b0;
      b_ready_i = 1'b0;
      forever begin
         @(negedge clk_i);
         r_ready_i = !bp_en || (($random(seed) & 3) != 0);
         b_ready_i = !bp_en || (($random(seed) & 3) != 0);
         if (r_valid_o && r_ready_i) begin
            if (exp_r_q.size() == 0) begin
               check_cond(1'b0, "R response with no read outstanding");
            end else begin
               exp = exp_r_q.pop_front();
               compare_value("r_id_o", r_id_o, exp.id);
               compare_value("r_data_o", r_data_o, exp.data);
               compare_value("r_resp_o", r_resp_o, exp.resp);
               compare_value("r_last_o", r_last_o, 1'b1);
            end
         end
         if (b_valid_o && b_ready_i) begin
            if (exp_b_q.size() == 0) begin
               check_cond(1'b0, "B response with no write outstanding");
            end else begin
               exp = exp_b_q.pop_front();
               compare_value("b_id_o", b_id_o, exp.id);
               compare_value("b_resp_o", b_resp_o, exp.resp);
            end
         end
         if (rst_n_i) check_cond(!per_req_o || busy_o, "busy_o low while per_req_o is high");
      end
   end

   //**************************************************
   // Peripheral model
   //**************************************************
   initial begin
      logic [31:0] addr;
      logic [31:0] word;
      logic        we;
      int          dly;
      per_wr_t     expw;
      per_gnt_i     = 1'b0;
      per_r_valid_i = 1'b0;
      per_r_opc_i   = 1'b0;
      per_r_rdata_i = '0;
      forever begin
         @(negedge clk_i);
         if (per_req_o) begin
            dly = $random(seed) & 3;
            repeat (dly) @(negedge clk_i);
            per_gnt_i = 1'b1;
            addr = per_add_o;
            we   = per_we_o;
            word = per_mem.exists(word_key(addr)) ? per_mem[word_key(addr)] : fill_word(addr);
            if (log_grants) grant_log.push_back(we);
            if (we) begin
               if (exp_wr_q.size() == 0) begin
                  check_cond(1'b0, "peripheral write with no AXI write outstanding");
               end else begin
                  expw = exp_wr_q.pop_front();
                  compare_value("per_add_o", per_add_o, expw.addr);
                  compare_value("per_wdata_o", per_wdata_o, expw.wdata);
                  compare_value("per_be_o", per_be_o, expw.be);
               end
               if (!err_region(addr)) begin
                  per_mem[word_key(addr)] = merge_bytes(word, per_wdata_o, per_be_o);
               end
            end
            @(negedge clk_i);
            per_gnt_i = 1'b0;
            dly = $unsigned($random(seed)) % 3 + 1;
            repeat (dly - 1) @(negedge clk_i);
            per_r_valid_i = 1'b1;
            per_r_opc_i   = err_region(addr);
            per_r_rdata_i = we ? 32'h0 : word;
            @(negedge clk_i);
            per_r_valid_i = 1'b0;
            per_r_opc_i   = 1'b0;
            per_r_rdata_i = '0;
         end
      end
   end

   initial begin
      repeat (WDOG_CYC) @(posedge clk_i);
      $display("Timeout: run did not finish within %0d cycles", WDOG_CYC);
      $display("TEST FAIL");
      $finish;
   end

   //**************************************************
   // Test sequence
   //**************************************************
   initial begin
      logic [31:0] addr;
      logic [7:0]  strb;
      logic [63:0] data;
      rst_n_i    = 1'b0;
      bp_en      = 1'b0;
      log_grants = 1'b0;
      aw_valid_i = 1'b0;
      aw_addr_i  = '0;
      aw_len_i   = 8'd0;
      aw_size_i  = 3'd2;
      aw_id_i    = '0;
      w_valid_i  = 1'b0;
      w_data_i   = '0;
      w_strb_i   = '0;
      w_last_i   = 1'b1;
      ar_valid_i = 1'b0;
      ar_addr_i  = '0;
      ar_len_i   = 8'd0;
      ar_size_i  = 3'd2;
      ar_id_i    = '0;
      repeat (RST_CYC) @(negedge clk_i);
      check_cond(!busy_o && !per_req_o && !r_valid_o && !b_valid_o,
                 "outputs not idle during reset");
      rst_n_i = 1'b1;
      @(negedge clk_i);
      finish_test("reset_state");

      // Both kinds stay pending so grants alternate
      log_grants = 1'b1;
      fork
         for (int i = 0; i < ARB_N; i++) issue_read(32'h0000_1000 + 32'(i) * 8, 3'(i));
         for (int i = 0; i < ARB_N; i++) begin
            issue_write(32'h0000_2000 + 32'(i) * 4, {2{32'(i) * 32'h0101_0101}}, 8'hff, 3'(i));
         end
      join
      drain();
      log_grants = 1'b0;
      check_cond(grant_log.size() == 2*ARB_N, "wrong number of grants in arbitration");
      foreach (grant_log[k]) begin
         compare_value($sformatf("per_we_o at grant %0d", k), grant_log[k], 64'(k % 2));
      end
      finish_test("arbitration");

      issue_write(32'h0000_0100, 64'h1111_2222_3333_4444, 8'hff, 3'd1);
      drain();
      issue_write(32'h0000_0104, 64'h5555_6666_7777_8888, 8'hff, 3'd2);
      drain();
      issue_read(32'h0000_0100, 3'd3);
      drain();
      issue_read(32'h0000_0104, 3'd4);
      finish_test("lane_mapping");

      for (int k = 0; k < BE_N; k++) begin
         addr = 32'h0000_3000 + 32'(k) * 4;
         issue_write(addr, 64'hdead_beef_cafe_f00d, 8'hff, 3'(k));
         drain();
         strb = 8'($random(seed));
         data = {$random(seed), $random(seed)};
         issue_write(addr, data, strb, 3'(k + 1));
         drain();
         issue_read(addr, 3'(k + 2));
         drain();
      end
      finish_test("byte_enables");

      issue_write(32'hf000_0010, 64'h0123_4567_89ab_cdef, 8'hff, 3'd5);
      drain();
      issue_read(32'hf000_0010, 3'd6);
      drain();
      issue_write(32'hf000_0014, 64'hfedc_ba98_7654_3210, 8'h30, 3'd7);
      drain();
      issue_read(32'hf000_0014, 3'd0);
      drain();
      issue_write(32'h0000_4000, 64'h0f0f_0f0f_a5a5_5a5a, 8'h0f, 3'd1);
      drain();
      issue_read(32'h0000_4000, 3'd2);
      finish_test("error_response");

      bp_en = 1'b1;
      fork
         for (int i = 0; i < BP_N; i++) issue_read(32'h0000_5000 + 32'(i) * 4, 3'($random(seed)));
         for (int i = 0; i < BP_N; i++) begin
            issue_write(32'h0000_6000 + 32'(i) * 4, {$random(seed), $random(seed)},
                        8'($random(seed)), 3'($random(seed)));
         end
      join
      drain();
      bp_en = 1'b0;
      finish_test("backpressure_id");

      // Busy spans the request up to the cycle after done
      fork
         issue_read(32'h0000_7000, 3'd5);
         begin
            @(negedge clk_i);
            while (!per_req_o) @(negedge clk_i);
            while (!r_valid_o) begin
               check_cond(busy_o, "busy_o low while a transaction is outstanding");
               @(negedge clk_i);
            end
            check_cond(busy_o, "busy_o low in the cycle after done");
         end
      join
      finish_test("busy_level");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, test_fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hdl/axi2per_bridge.sv ====
/*
 * AXI4 slave to 32-bit peripheral interconnect bridge, single beats only.
 * Every AXI channel passes a one-entry slice; the request and response
 * channels meet through the transaction interface.
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi2per_consts.svh"

module axi2per_bridge
   import axi2per_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   //**************************************************
   // AXI slave
   //**************************************************
   input  logic                       aw_valid_i,
   output logic                       aw_ready_o,
   input  logic [`AXI_ADDR_W-1:0]     aw_addr_i,
   input  logic [7:0]                 aw_len_i,
   input  logic [2:0]                 aw_size_i,
   input  logic [`AXI_ID_W-1:0]       aw_id_i,

   input  logic                       w_valid_i,
   output logic                       w_ready_o,
   input  logic [`AXI_DATA_W-1:0]     w_data_i,
   input  logic [`AXI_DATA_W/8-1:0]   w_strb_i,
   input  logic                       w_last_i,

   input  logic                       ar_valid_i,
   output logic                       ar_ready_o,
   input  logic [`AXI_ADDR_W-1:0]     ar_addr_i,
   input  logic [7:0]                 ar_len_i,
   input  logic [2:0]                 ar_size_i,
   input  logic [`AXI_ID_W-1:0]       ar_id_i,

   output logic                       r_valid_o,
   input  logic                       r_ready_i,
   output logic [`AXI_DATA_W-1:0]     r_data_o,
   output logic [1:0]                 r_resp_o,
   output logic                       r_last_o,
   output logic [`AXI_ID_W-1:0]       r_id_o,

   output logic                       b_valid_o,
   input  logic                       b_ready_i,
   output logic [1:0]                 b_resp_o,
   output logic [`AXI_ID_W-1:0]       b_id_o,

   //**************************************************
   // Peripheral master
   //**************************************************
   output logic                       per_req_o,
   output logic [`AXI_ADDR_W-1:0]     per_add_o,
   output logic                       per_we_o,
   output logic [`PER_DATA_W-1:0]     per_wdata_o,
   output logic [`PER_DATA_W/8-1:0]   per_be_o,
   input  logic                       per_gnt_i,
   input  logic                       per_r_valid_i,
   input  logic                       per_r_opc_i,
   input  logic [`PER_DATA_W-1:0]     per_r_rdata_i,

   output logic                       busy_o
);

   addr_chan_t aw_in, aw_out, ar_in, ar_out;
   w_chan_t    w_in, w_out;
   r_chan_t    r_in, r_out;
   b_chan_t    b_in, b_out;
   logic       aw_v, aw_r, ar_v, ar_r, w_v, w_r;
   logic       r_v, r_r, b_v, b_r;

   axi2per_trans_if trans_if ();

   // Pack plain ports into channel payloads
   assign aw_in = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i, size: aw_size_i};
   assign ar_in = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i, size: ar_size_i};
   assign w_in  = '{data: w_data_i, strb: w_strb_i, last: w_last_i};

   axi2per_chan_slice #(.payload_t(addr_chan_t)) aw_slice (
      .clk_i, .rst_n_i,
      .in_valid_i (aw_valid_i), .in_ready_o (aw_ready_o), .in_data_i (aw_in),
      .out_valid_o(aw_v),       .out_ready_i(aw_r),       .out_data_o(aw_out)
   );

   axi2per_chan_slice #(.payload_t(addr_chan_t)) ar_slice (
      .clk_i, .rst_n_i,
      .in_valid_i (ar_valid_i), .in_ready_o (ar_ready_o), .in_data_i (ar_in),
      .out_valid_o(ar_v),       .out_ready_i(ar_r),       .out_data_o(ar_out)
   );

   axi2per_chan_slice #(.payload_t(w_chan_t)) w_slice (
      .clk_i, .rst_n_i,
      .in_valid_i (w_valid_i), .in_ready_o (w_ready_o), .in_data_i (w_in),
      .out_valid_o(w_v),       .out_ready_i(w_r),       .out_data_o(w_out)
   );

   axi2per_req_channel req_chan (
      .clk_i, .rst_n_i,
      .ar_valid_i(ar_v), .ar_ready_o(ar_r), .ar_data_i(ar_out),
      .aw_valid_i(aw_v), .aw_ready_o(aw_r), .aw_data_i(aw_out),
      .w_valid_i (w_v),  .w_ready_o (w_r),  .w_data_i (w_out),
      .per_req_o, .per_add_o, .per_we_o, .per_wdata_o, .per_be_o, .per_gnt_i,
      .trans     (trans_if.req_mp),
      .busy_o
   );

   axi2per_res_channel res_chan (
      .clk_i, .rst_n_i,
      .trans     (trans_if.res_mp),
      .per_r_valid_i, .per_r_opc_i, .per_r_rdata_i,
      .r_valid_o(r_v), .r_ready_i(r_r), .r_data_o(r_in),
      .b_valid_o(b_v), .b_ready_i(b_r), .b_data_o(b_in)
   );

   axi2per_chan_slice #(.payload_t(r_chan_t)) r_slice (
      .clk_i, .rst_n_i,
      .in_valid_i (r_v),       .in_ready_o (r_r),       .in_data_i (r_in),
      .out_valid_o(r_valid_o), .out_ready_i(r_ready_i), .out_data_o(r_out)
   );

   axi2per_chan_slice #(.payload_t(b_chan_t)) b_slice (
      .clk_i, .rst_n_i,
      .in_valid_i (b_v),       .in_ready_o (b_r),       .in_data_i (b_in),
      .out_valid_o(b_valid_o), .out_ready_i(b_ready_i), .out_data_o(b_out)
   );

   // Unpack replies onto plain ports
   assign r_data_o = r_out.data;
   assign r_resp_o = r_out.resp;
   assign r_last_o = r_out.last;
   assign r_id_o   = r_out.id;
   assign b_resp_o = b_out.resp;
   assign b_id_o   = b_out.id;

endmodule

`default_nettype wire

// ==== hdl/axi2per_res_channel.sv ====
/*
 * Response side of the bridge. Latches the granted transaction, captures
 * the peripheral reply and offers it as an R or B payload. done pulses when
 * the output slice takes the payload.
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi2per_consts.svh"

module axi2per_res_channel
   import axi2per_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   axi2per_trans_if.res_mp        trans,

   input  logic                   per_r_valid_i,
   input  logic                   per_r_opc_i,
   input  logic [`PER_DATA_W-1:0] per_r_rdata_i,

   output logic                   r_valid_o,
   input  logic                   r_ready_i,
   output r_chan_t                r_data_o,
   output logic                   b_valid_o,
   input  logic                   b_ready_i,
   output b_chan_t                b_data_o
);

   logic                   outst_q;
   logic                   pend_q;
   logic                   accept;

   logic                   we_q;
   logic                   lane_q;
   logic [`AXI_ID_W-1:0]   id_q;
   logic [1:0]             resp_q;
   logic [`PER_DATA_W-1:0] rdata_q;
   logic [`AXI_DATA_W-1:0] rd_word;

   assign accept = pend_q && (we_q ? b_ready_i : r_ready_i);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         outst_q <= 1'b0;
         pend_q  <= 1'b0;
      end else begin
         if (trans.valid) begin
            outst_q <= 1'b1;
         end
         if (per_r_valid_i) begin
            outst_q <= 1'b0;
            pend_q  <= 1'b1;
         end else if (accept) begin
            pend_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (trans.valid) begin
         we_q   <= trans.we;
         lane_q <= trans.lane;
         id_q   <= trans.id;
      end
      if (per_r_valid_i) begin
         resp_q  <= per_r_opc_i ? `RESP_SLVERR : `RESP_OKAY;
         rdata_q <= per_r_rdata_i;
      end
   end

   //**************************************************
   // Reply payloads
   //**************************************************
   // Unselected lane reads as zero
   assign rd_word = lane_q ? {rdata_q, {`PER_DATA_W{1'b0}}}
                           : {{`PER_DATA_W{1'b0}}, rdata_q};

   assign r_valid_o     = pend_q && !we_q;
   assign r_data_o.id   = id_q;
   assign r_data_o.data = rd_word;
   assign r_data_o.resp = resp_q;
   assign r_data_o.last = 1'b1;

   assign b_valid_o     = pend_q && we_q;
   assign b_data_o.id   = id_q;
   assign b_data_o.resp = resp_q;

   assign trans.done = accept;

   a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      per_r_valid_i |-> outst_q)
      else $error("Peripheral response without outstanding request");

endmodule

`default_nettype wire

// ==== hdl/axi2per_req_channel.sv ====
/*
 * Request side of the bridge. Arbitrates between a pending read and a
 * pending write, picks the 32-bit lane from address bit 2 and holds the
 * peripheral request until grant. One transaction is outstanding at a time.
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi2per_consts.svh"

module axi2per_req_channel
   import axi2per_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       ar_valid_i,
   output logic                       ar_ready_o,
   input  addr_chan_t                 ar_data_i,
   input  logic                       aw_valid_i,
   output logic                       aw_ready_o,
   input  addr_chan_t                 aw_data_i,
   input  logic                       w_valid_i,
   output logic                       w_ready_o,
   input  w_chan_t                    w_data_i,

   output logic                       per_req_o,
   output logic [`AXI_ADDR_W-1:0]     per_add_o,
   output logic                       per_we_o,
   output logic [`PER_DATA_W-1:0]     per_wdata_o,
   output logic [`PER_DATA_W/8-1:0]   per_be_o,
   input  logic                       per_gnt_i,

   axi2per_trans_if.req_mp            trans,
   output logic                       busy_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

   state_t                   state_q;
   logic                     last_we_q;
   logic                     done_q;
   logic                     rd_pend;
   logic                     wr_pend;
   logic                     pick_wr;
   logic                     issue;
   logic                     grant;
   logic                     wr_lane;

   logic [`AXI_ADDR_W-1:0]   add_q;
   logic                     we_q;
   logic [`PER_DATA_W-1:0]   wdata_q;
   logic [`PER_DATA_W/8-1:0] be_q;
   logic [`AXI_ID_W-1:0]     id_q;

   //**************************************************
   // Arbitration
   //**************************************************
   assign rd_pend = ar_valid_i;
   assign wr_pend = aw_valid_i && w_valid_i;
   // Opposite of last served kind wins a tie
   assign pick_wr = wr_pend && (!rd_pend || !last_we_q);
   assign issue   = (state_q == ST_IDLE) && (rd_pend || wr_pend);
   assign grant   = (state_q == ST_REQ) && per_gnt_i;
   assign wr_lane = aw_data_i.addr[2];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_IDLE;
         last_we_q <= 1'b1;
         done_q    <= 1'b0;
      end else begin
         done_q <= trans.done;
         case (state_q)
            ST_IDLE: if (issue) state_q <= ST_REQ;
            ST_REQ: begin
               if (per_gnt_i) begin
                  state_q   <= ST_WAIT;
                  last_we_q <= we_q;
               end
            end
            ST_WAIT: if (trans.done) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Request fields captured when leaving idle
   always_ff @(posedge clk_i) begin
      if (issue) begin
         we_q <= pick_wr;
         if (pick_wr) begin
            add_q   <= aw_data_i.addr;
            id_q    <= aw_data_i.id;
            wdata_q <= w_data_i.data[wr_lane*`PER_DATA_W +: `PER_DATA_W];
            be_q    <= w_data_i.strb[wr_lane*(`PER_DATA_W/8) +: `PER_DATA_W/8];
         end else begin
            add_q   <= ar_data_i.addr;
            id_q    <= ar_data_i.id;
            wdata_q <= '0;
            be_q    <= '1;
         end
      end
   end

   //**************************************************
   // Peripheral request and slice pops
   //**************************************************
   assign per_req_o   = (state_q == ST_REQ);
   assign per_add_o   = add_q;
   assign per_we_o    = we_q;
   assign per_wdata_o = wdata_q;
   assign per_be_o    = be_q;

   assign ar_ready_o = grant && !we_q;
   assign aw_ready_o = grant && we_q;
   assign w_ready_o  = grant && we_q;

   assign trans.valid = grant;
   assign trans.we    = we_q;
   assign trans.id    = id_q;
   assign trans.lane  = add_q[2];

   // Held one extra cycle past done
   assign busy_o = (state_q != ST_IDLE) || done_q;

   a_ar_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ar_valid_i |-> ar_data_i.len == 8'd0 && ar_data_i.size <= `AXI_MAX_SIZE)
      else $error("AR burst or wide beat not supported");

   a_aw_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      aw_valid_i |-> aw_data_i.len == 8'd0 && aw_data_i.size <= `AXI_MAX_SIZE)
      else $error("AW burst or wide beat not supported");

   a_w_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      w_valid_i |-> w_data_i.last)
      else $error("W beat without last not supported");

   a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      per_req_o && !per_gnt_i |=>
         per_req_o && $stable({per_add_o, per_we_o, per_wdata_o, per_be_o}))
      else $error("Peripheral request dropped or changed before grant");

endmodule

`default_nettype wire

// ==== hdl/axi2per_chan_slice.sv ====
/*
 * One-entry valid/ready register slice. The payload type is a parameter so
 * the same slice serves all five AXI channels.
 */
`timescale 1ns/1ns
`default_nettype none

module axi2per_chan_slice #(
   parameter type payload_t = logic
) (
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  logic     in_valid_i,
   output logic     in_ready_o,
   input  payload_t in_data_i,

   output logic     out_valid_o,
   input  logic     out_ready_i,
   output payload_t out_data_o
);

   logic     full_q;
   payload_t data_q;

   assign in_ready_o  = !full_q;
   assign out_valid_o = full_q;
   assign out_data_o  = data_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         full_q <= 1'b0;
      end else if (in_valid_i && !full_q) begin
         full_q <= 1'b1;
      end else if (full_q && out_ready_i) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (in_valid_i && !full_q) begin
         data_q <= in_data_i;
      end
   end

   a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else $error("Slice payload changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/axi2per_trans_if.sv ====
/*
 * Carries one granted transaction from the request channel to the response
 * channel, and the done pulse back once the AXI reply is taken.
 */
`timescale 1ns/1ns
`default_nettype none

`include "axi2per_consts.svh"

interface axi2per_trans_if;

   logic                 valid;
   logic                 we;
   logic [`AXI_ID_W-1:0] id;
   // Address bit 2 of the transaction
   logic                 lane;
   logic                 done;

   modport req_mp (output valid, we, id, lane, input done);
   modport res_mp (input valid, we, id, lane, output done);

endinterface

`default_nettype wire

// ==== hdl/axi2per_pkg.sv ====
/*
 * Channel payload types of the AXI4 to peripheral bridge.
 * Modules take them with a wildcard import in their header.
 */
`default_nettype none

`include "axi2per_consts.svh"

package axi2per_pkg;

   // AW and AR share one payload layout
   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      logic [`AXI_ADDR_W-1:0] addr;
      logic [7:0]             len;
      logic [2:0]             size;
   } addr_chan_t;

   typedef struct packed {
      logic [`AXI_DATA_W-1:0]   data;
      logic [`AXI_DATA_W/8-1:0] strb;
      logic                     last;
   } w_chan_t;

   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      logic [`AXI_DATA_W-1:0] data;
      logic [1:0]             resp;
      logic                   last;
   } r_chan_t;

   typedef struct packed {
      logic [`AXI_ID_W-1:0] id;
      logic [1:0]           resp;
   } b_chan_t;

endpackage

`default_nettype wire

// ==== include/axi2per_consts.svh ====
/*
 * Width, response code and beat size constants for the AXI4 to peripheral
 * bridge. Included by every design file that sizes a port or a field.
 */
`ifndef AXI2PER_CONSTS_SVH
`define AXI2PER_CONSTS_SVH

// AXI slave side
`define AXI_ADDR_W   32
`define AXI_DATA_W   64
`define AXI_ID_W     3

// Peripheral interconnect side
`define PER_DATA_W   32

// Largest accepted beat size code (4 bytes)
`define AXI_MAX_SIZE 3'd2

// AXI response encodings
`define RESP_OKAY    2'b00
`define RESP_SLVERR  2'b10

`endif
